/* verilog/rv_cfg.svh */
// Core configuration macros for data width, reset PC, register count and address width
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data path and address width
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Integer register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

/* verilog/rvIsaPkg.sv */
// RV32I opcode and funct3 constants plus the instruction word union
package rvIsaPkg;

    // Major opcodes handled by the core
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // ALU funct3 field shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;  // Also B-type offset high bits
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    // One fetched word seen through each encoding
    typedef union packed {
        logic [31:0] raw;
        rTypeT       rType;
        iTypeT       iType;
        sTypeT       sType;
    } instrU;

endpackage

/* verilog/rvCtrlPkg.sv */
// Datapath control types for ALU operation, write-back source and access size
package rvCtrlPkg;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10   // LUI forwards the immediate
    } aluOpT;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,   // ALU result
        WB_MEM   = 2'b01,   // Load data
        WB_PC4   = 2'b10,   // Link address for JAL and JALR
        WB_PCIMM = 2'b11    // AUIPC
    } wbSelT;

    // Memory access width matching funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } memSizeT;

endpackage

/* verilog/controller.sv */
// Main decoder from instruction fields to datapath control signals
`timescale 1ns/10ps

module controller
    import rvIsaPkg::*, rvCtrlPkg::*;
(
    input  instrU   instr,
    output logic    regWrite,
    output logic    memWrite,
    output logic    isBranch,
    output logic    isJal,
    output logic    isJalr,
    output logic    aluSrcImm,     // Second ALU operand is the immediate
    output logic    loadUnsigned,
    output wbSelT   wbSel,
    output aluOpT   aluOp,
    output memSizeT memSize
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.iType.funct3;
    assign funct7 = instr.rType.funct7;

    // Unit enables straight from the opcode
    assign memWrite  = (opcode == OP_STORE);
    assign isBranch  = (opcode == OP_BRANCH);
    assign isJal     = (opcode == OP_JAL);
    assign isJalr    = (opcode == OP_JALR);

    assign regWrite  = (opcode == OP_REG)  || (opcode == OP_IMM)   ||
                       (opcode == OP_LOAD) || (opcode == OP_JALR)  ||
                       (opcode == OP_JAL)  || (opcode == OP_LUI)   ||
                       (opcode == OP_AUIPC);

    assign aluSrcImm = (opcode == OP_IMM)   || (opcode == OP_LOAD) ||
                       (opcode == OP_STORE) || (opcode == OP_LUI)  ||
                       (opcode == OP_JALR);

    // Size and sign come from funct3 for both loads and stores
    assign memSize = (funct3[1:0] == 2'b00) ? SZ_BYTE :
                     (funct3[1:0] == 2'b01) ? SZ_HALF : SZ_WORD;
    assign loadUnsigned = (opcode == OP_LOAD) && funct3[2];

    always_comb begin
        case (opcode)
            OP_LOAD:         wbSel = WB_MEM;
            OP_JAL, OP_JALR: wbSel = WB_PC4;
            OP_AUIPC:        wbSel = WB_PCIMM;
            default:         wbSel = WB_ALU;
        endcase
    end

    // Loads, stores and JALR fall through to the address add
    always_comb begin
        aluOp = ALU_ADD;
        if (opcode == OP_LUI) begin
            aluOp = ALU_PASSB;
        end else if (opcode == OP_REG || opcode == OP_IMM) begin
            case (funct3)
                F3_ADD:  aluOp = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
                F3_SLL:  aluOp = ALU_SLL;
                F3_SLT:  aluOp = ALU_SLT;
                F3_SLTU: aluOp = ALU_SLTU;
                F3_XOR:  aluOp = ALU_XOR;
                F3_SR:   aluOp = funct7[5] ? ALU_SRA : ALU_SRL;  // SRAI keeps imm[10] set
                F3_OR:   aluOp = ALU_OR;
                F3_AND:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

endmodule

/* verilog/immGen.sv */
// Sign-extended immediate builder for the I, S, B, U and J formats
`timescale 1ns/10ps
`include "rv_cfg.svh"

module immGen
    import rvIsaPkg::*;
(
    input  instrU             instr,
    output logic [`XLEN-1:0]  imm
);

    always_comb begin
        case (instr.rType.opcode)
            OP_LOAD, OP_IMM, OP_JALR: begin
                imm = {{(`XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};
            end
            OP_STORE: begin
                imm = {{(`XLEN-12){instr.sType.immHi[6]}}, instr.sType.immHi,
                       instr.sType.immLo};
            end
            OP_BRANCH: begin
                // imm[12|10:5] in immHi, imm[4:1|11] in immLo
                imm = {{(`XLEN-12){instr.sType.immHi[6]}}, instr.sType.immLo[0],
                       instr.sType.immHi[5:0], instr.sType.immLo[4:1], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instr.raw[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{(`XLEN-20){instr.raw[31]}}, instr.raw[19:12], instr.raw[20],
                       instr.raw[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

/* verilog/alu.sv */
// Integer ALU with shifter and branch comparator
`timescale 1ns/10ps
`include "rv_cfg.svh"

module alu
    import rvCtrlPkg::*;
(
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    input  aluOpT            aluOp,
    input  logic [2:0]       funct3,
    output logic [`XLEN-1:0] aluResult,
    output logic             brTaken
);

    logic [4:0] shamt;

    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            ALU_ADD:   aluResult = opA + opB;
            ALU_SUB:   aluResult = opA - opB;
            ALU_SLL:   aluResult = opA << shamt;
            ALU_SLT:   aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluResult = {{(`XLEN-1){1'b0}}, opA < opB};
            ALU_XOR:   aluResult = opA ^ opB;
            ALU_SRL:   aluResult = opA >> shamt;
            ALU_SRA:   aluResult = $unsigned($signed(opA) >>> shamt);
            ALU_OR:    aluResult = opA | opB;
            ALU_AND:   aluResult = opA & opB;
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    // Branch condition from the B-type funct3
    always_comb begin
        case (funct3)
            3'b000:  brTaken = (opA == opB);                   // BEQ
            3'b001:  brTaken = (opA != opB);                   // BNE
            3'b100:  brTaken = $signed(opA) < $signed(opB);    // BLT
            3'b101:  brTaken = $signed(opA) >= $signed(opB);   // BGE
            3'b110:  brTaken = opA < opB;                      // BLTU
            3'b111:  brTaken = opA >= opB;                     // BGEU
            default: brTaken = 1'b0;
        endcase
    end

endmodule

/* verilog/regFile.sv */
// Integer register file with two read ports, one write port and zero register
`timescale 1ns/10ps
`include "rv_cfg.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    input  logic [`XLEN-1:0]       wdata,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    // Architectural state feeding the ALU operands
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;  // x0 writes dropped
        end
    end

    // Combinational reads with x0 tied to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* verilog/loadStoreUnit.sv */
// Load and store lane handling with byte write mask and load extension
`timescale 1ns/10ps
`include "rv_cfg.svh"

module loadStoreUnit
    import rvCtrlPkg::*;
(
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] storeData,
    input  logic [`XLEN-1:0] memRData,
    input  memSizeT          memSize,
    input  logic             loadUnsigned,
    input  logic             memWriteReq,
    output logic [`XLEN-1:0] memAddr,
    output logic [`XLEN-1:0] memWData,
    output logic [`XLEN-1:0] loadData,
    output logic [3:0]       memWMask,
    output logic             memWrite
);

    logic [3:0]       laneMask;
    logic [`XLEN-1:0] laneWord;  // Addressed lane moved down to bit 0

    assign memAddr  = {addr[`XLEN-1:2], 2'b00};
    assign memWrite = memWriteReq;
    assign memWMask = memWriteReq ? laneMask : 4'b0000;

    // Store data copied into every lane and masked down to the live ones
    always_comb begin
        case (memSize)
            SZ_BYTE: begin
                memWData = {(`XLEN/8){storeData[7:0]}};
                laneMask = 4'b0001 << addr[1:0];
            end
            SZ_HALF: begin
                memWData = {(`XLEN/16){storeData[15:0]}};
                laneMask = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                memWData = storeData;
                laneMask = 4'b1111;
            end
        endcase
    end

    assign laneWord = memRData >> {addr[1:0], 3'b000};

    always_comb begin
        case (memSize)
            SZ_BYTE: loadData = {{(`XLEN-8){~loadUnsigned & laneWord[7]}}, laneWord[7:0]};
            SZ_HALF: loadData = {{(`XLEN-16){~loadUnsigned & laneWord[15]}}, laneWord[15:0]};
            default: loadData = memRData;
        endcase
    end

endmodule

/* verilog/rvCore.sv */
// Single-cycle RV32I core top with PC register, next-PC and write-back selection
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rvCore
    import rvIsaPkg::*, rvCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`XLEN-1:0]       instr,
    input  logic [`XLEN-1:0]       memRData,
    output logic [`XLEN-1:0]       pc,
    output logic [`XLEN-1:0]       memAddr,
    output logic [`XLEN-1:0]       memWData,
    output logic [3:0]             memWMask,
    output logic                   memWrite,
    output logic                   wbEn,
    output logic [`REG_ADDR_W-1:0] wbAddr,
    output logic [`XLEN-1:0]       wbData
);

    instrU            instrW;
    logic             regWrite, ctrlMemWrite, isBranch, isJal, isJalr;
    logic             aluSrcImm, loadUnsigned, brTaken;
    wbSelT            wbSel;
    aluOpT            aluOp;
    memSizeT          memSize;
    logic [`XLEN-1:0] imm, rs1Data, rs2Data, aluResult, loadData;
    logic [`XLEN-1:0] pcPlus4, pcPlusImm, nextPc;

    assign instrW = instr;

    controller u_controller (.instr(instrW), .regWrite, .memWrite(ctrlMemWrite), .isBranch,
        .isJal, .isJalr, .aluSrcImm, .loadUnsigned, .wbSel, .aluOp, .memSize);

    immGen u_immGen (.instr(instrW), .imm);

    regFile u_regFile (.clk, .rst, .we(wbEn), .waddr(wbAddr), .raddr1(instrW.rType.rs1),
        .raddr2(instrW.rType.rs2), .wdata(wbData), .rdata1(rs1Data), .rdata2(rs2Data));

    alu u_alu (.opA(rs1Data), .opB(aluSrcImm ? imm : rs2Data), .aluOp,
        .funct3(instrW.rType.funct3), .aluResult, .brTaken);

    // No store may reach memory while in reset
    loadStoreUnit u_loadStoreUnit (.addr(aluResult), .storeData(rs2Data), .memRData,
        .memSize, .loadUnsigned, .memWriteReq(ctrlMemWrite & ~rst), .memAddr, .memWData,
        .loadData, .memWMask, .memWrite);

    assign pcPlus4   = pc + `XLEN'd4;
    assign pcPlusImm = pc + imm;

    // JALR target first, then taken branch or JAL
    assign nextPc = isJalr ? {aluResult[`XLEN-1:1], 1'b0} :
                    (isJal || (isBranch && brTaken)) ? pcPlusImm : pcPlus4;

    always_ff @(posedge clk) begin
        if (rst) pc <= `RESET_PC;
        else     pc <= nextPc;
    end

    assign wbEn   = regWrite & ~rst;
    assign wbAddr = instrW.rType.rd;

    always_comb begin
        case (wbSel)
            WB_MEM:   wbData = loadData;
            WB_PC4:   wbData = pcPlus4;    // Link address
            WB_PCIMM: wbData = pcPlusImm;
            default:  wbData = aluResult;
        endcase
    end

endmodule

/* verif/rvCore_assert.sv */
// Concurrent assertions on PC alignment, reset state and write exclusivity for rvCore
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rvCoreAssert (
    input logic             clk,
    input logic             rst,
    input logic [`XLEN-1:0] pc,
    input logic             memWrite,
    input logic             wbEn
);

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    // Reset value visible in the first cycle after rst
    pcAfterReset: assert property (@(posedge clk) rst |=> pc == `RESET_PC)
        else $error("pc not at reset address after reset");

    storeOrWrite: assert property (@(posedge clk) !(memWrite && wbEn))
        else $error("memWrite and wbEn high together");

    quietInReset: assert property (@(posedge clk) rst |-> (!memWrite && !wbEn))
        else $error("write strobe active during reset");

endmodule

bind rvCore rvCoreAssert u_rvCoreAssert (.clk, .rst, .pc, .memWrite, .wbEn);

/* verif/rvCore_tb.sv */
// Testbench for rvCore with random program, ISA reference model and memory models
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rvCore_tb
    import rvIsaPkg::*;
();

    localparam int NUM_INSTR    = 600;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_INSTR + 95;

    logic clk, rst;
    logic [31:0] instr, memRData, pc, memAddr, memWData, wbData;
    logic [3:0] memWMask;
    logic memWrite, wbEn;
    logic [4:0] wbAddr;

    logic [31:0] imem [256];
    logic [31:0] tbMem [64];      // Memory seen by the DUT
    logic [31:0] modelMem [64];   // Reference model copy
    logic [31:0] modelReg [32];
    logic [31:0] modelPc;
    integer seed;
    integer errors = 0;
    integer checks = 0;
    integer cycles = 0;

    // Expected results of the current instruction
    logic expWbEn, expStore;
    logic [4:0] expRd;
    logic [31:0] expWb, expAddr, expSData, nextPc;
    logic [3:0] expMask;

    rvCore u_rvCore (.clk, .rst, .instr, .memRData, .pc, .memAddr, .memWData, .memWMask,
        .memWrite, .wbEn, .wbAddr, .wbData);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    assign memRData = tbMem[memAddr[7:2]];  // Combinational read

    always @(posedge clk) begin
        if (memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (memWMask[b]) tbMem[memAddr[7:2]][8*b +: 8] <= memWData[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("error %s: got %h expected %h at pc %h", name, got, expected, modelPc);
            errors++;
        end
    endtask

    function automatic logic [31:0] randBelow(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [31:0] laneBits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Fills imem with legal instructions whose branch targets stay inside the program
    task automatic genProgram();
        int i, t;
        logic [31:0] r, off, tw;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [11:0] imm12;
        logic [7:0] addr;
        logic alt;
        i = 0;
        while (i < 256) begin
            r = randBelow(31);
            rd = r[4:0];                 // x31 reserved as JALR base
            r = randBelow(32);
            rs1 = r[4:0];
            r = randBelow(32);
            rs2 = r[4:0];
            r = randBelow(8);
            f3 = r[2:0];
            r = randBelow(2);
            alt = r[0];
            r = randBelow(256);
            addr = r[7:0];
            t = int'(randBelow(256));
            if (t == i) t = (i + 1) % 256;
            off = (t - i) * 4;
            tw = t * 4;
            r = $random(seed);
            case (randBelow(11))
                0, 1, 2: begin
                    imm12 = r[11:0];
                    if (f3 == 3'd1) imm12 = {7'b0, r[4:0]};
                    else if (f3 == 3'd5) imm12 = {1'b0, alt, 5'b0, r[4:0]};
                    imem[i] = {imm12, rs1, f3, rd, OP_IMM};
                end
                3, 4: begin
                    imm12 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, alt, 10'b0} : 12'b0;
                    imem[i] = {imm12[11:5], rs2, rs1, f3, rd, OP_REG};
                end
                5: imem[i] = {r[19:0], rd, alt ? OP_LUI : OP_AUIPC};
                6: begin
                    if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4;
                    imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
                end
                7: imem[i] = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
                8, 9: begin
                    f3 = f3 % 3'd3;
                    addr = addr & (8'hFF << f3[1:0]);
                    imm12 = {4'b0, addr};
                    if (randBelow(2) == 0) begin
                        if (f3 != 3'd2 && alt) f3 = f3 + 3'd4;
                        imem[i] = {imm12, 5'd0, f3, rd, OP_LOAD};
                    end else begin
                        imem[i] = {imm12[11:5], rs2, 5'd0, f3, imm12[4:0], OP_STORE};
                    end
                end
                default: begin
                    imem[i] = {tw[11:0], 5'd0, 3'b000, 5'd31, OP_IMM};
                    if (i < 255) begin
                        i++;
                        imem[i] = {12'd1, 5'd31, 3'b000, rd, OP_JALR};  // Odd sum with bit 0 cleared
                    end
                end
            endcase
            i++;
        end
    endtask

    task automatic execStep(input logic [31:0] ins);
        logic [31:0] a, b, immI, immS, immB, immU, immJ, addr, w;
        logic [2:0] f3;
        a = modelReg[ins[19:15]];
        b = modelReg[ins[24:20]];
        f3 = ins[14:12];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'b0};
        immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        expWbEn = 1'b1;
        expRd = ins[11:7];
        expWb = '0;
        expStore = 1'b0;
        expAddr = '0;
        expMask = '0;
        expSData = '0;
        nextPc = modelPc + 32'd4;
        case (ins[6:0])
            OP_LUI:   expWb = immU;
            OP_AUIPC: expWb = modelPc + immU;
            OP_JAL: begin
                expWb = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            OP_JALR: begin
                expWb = modelPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            OP_BRANCH: begin
                expWbEn = 1'b0;
                if (branchTaken(f3, a, b)) nextPc = modelPc + immB;
            end
            OP_IMM: expWb = aluRef(f3, ins[30] && f3 == 3'd5, a, immI);
            OP_REG: expWb = aluRef(f3, ins[30], a, b);
            OP_LOAD: begin
                addr = a + immI;
                w = modelMem[addr[7:2]] >> {addr[1:0], 3'b000};
                case (f3)
                    3'd0:    expWb = {{24{w[7]}}, w[7:0]};
                    3'd1:    expWb = {{16{w[15]}}, w[15:0]};
                    3'd4:    expWb = {24'b0, w[7:0]};
                    3'd5:    expWb = {16'b0, w[15:0]};
                    default: expWb = modelMem[addr[7:2]];
                endcase
            end
            default: begin
                // Store with lanes placed by the low address bits
                addr = a + immS;
                expWbEn = 1'b0;
                expStore = 1'b1;
                expAddr = {addr[31:2], 2'b00};
                case (f3[1:0])
                    2'd0: begin
                        expMask = 4'b0001 << addr[1:0];
                        expSData = {24'b0, b[7:0]} << {addr[1:0], 3'b000};
                    end
                    2'd1: begin
                        expMask = 4'b0011 << addr[1:0];
                        expSData = {16'b0, b[15:0]} << {addr[1:0], 3'b000};
                    end
                    default: begin
                        expMask = 4'b1111;
                        expSData = b;
                    end
                endcase
            end
        endcase
    endtask

    task automatic commitStep();
        if (expWbEn && expRd != 5'd0) modelReg[expRd] = expWb;
        if (expStore) begin
            modelMem[expAddr[7:2]] = (modelMem[expAddr[7:2]] & ~laneBits(expMask)) |
                                     (expSData & laneBits(expMask));
        end
        modelPc = nextPc;
    endtask

    initial begin
        logic [31:0] jw;
        seed = 78;
        rst = 1'b1;
        instr = 32'h0000_0013;   // ADDI x0, x0, 0
        modelPc = `RESET_PC;
        for (int j = 0; j < 32; j++) modelReg[j] = '0;
        for (int j = 0; j < 64; j++) begin
            jw = j;
            tbMem[j] = (jw * 32'h9E37_79B1) ^ {jw[7:0], ~jw[7:0], jw[7:0], 8'hA5};
            modelMem[j] = tbMem[j];
        end
        genProgram();
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #1;
        checkValue("wbEn", {31'b0, wbEn}, 32'd0);
        // Last reset cycle carries a store that must stay off the bus
        instr = {7'd0, 5'd1, 5'd0, 3'b010, 5'd0, OP_STORE};
        @(posedge clk);
        #1;
        checkValue("memWrite", {31'b0, memWrite}, 32'd0);
        checkValue("memWMask", {28'b0, memWMask}, 32'd0);
        rst = 1'b0;
        repeat (NUM_INSTR) begin
            checkValue("pc", pc, modelPc);
            instr = imem[pc[9:2]];
            execStep(instr);
            @(negedge clk);
            checkValue("wbEn", {31'b0, wbEn}, {31'b0, expWbEn});
            if (expWbEn) begin
                checkValue("wbAddr", {27'b0, wbAddr}, {27'b0, expRd});
                checkValue("wbData", wbData, expWb);
            end
            checkValue("memWrite", {31'b0, memWrite}, {31'b0, expStore});
            if (expStore) begin
                checkValue("memAddr", memAddr, expAddr);
                checkValue("memWMask", {28'b0, memWMask}, {28'b0, expMask});
                checkValue("memWData", memWData & laneBits(expMask), expSData);
            end
            commitStep();
            @(posedge clk);
            #1;
        end
        $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* rvCore.f */
+incdir+verilog
verilog/rvIsaPkg.sv
verilog/rvCtrlPkg.sv
verilog/controller.sv
verilog/immGen.sv
verilog/alu.sv
verilog/regFile.sv
verilog/loadStoreUnit.sv
verilog/rvCore.sv
verif/rvCore_assert.sv
verif/rvCore_tb.sv

/* Makefile */
# Verilator build and run for the rvCore testbench

VERILATOR ?= verilator
TOP       ?= rvCore_tb
FLIST     ?= rvCore.f
OBJDIR    ?= obj_dir

SIM = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)

# Pass only when the pass line shows up in the simulation output
run: compile
	./$(SIM) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)
